/* source/mac_defines.svh */
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// operand width, both a and b
`define MAC_IN_W   16

// full signed product of two operands
`define MAC_PROD_W 32

// accumulator, product plus 8 guard bits
`define MAC_ACC_W  40

// saturated result handed back to the host
`define MAC_OUT_W  32

`endif

/* source/macPkg.sv */
package macPkg;

    `include "mac_defines.svh"

    ////////////////////////////////////////////////////////////////////////////
    // command codes
    ////////////////////////////////////////////////////////////////////////////

    // code 3 is reserved, the datapath treats it as clear
    typedef enum logic [1:0] {
        opMul   = 2'd0,
        opMac   = 2'd1,
        opClear = 2'd2
    } macOpT;

    ////////////////////////////////////////////////////////////////////////////
    // handshake words
    ////////////////////////////////////////////////////////////////////////////

    // command word, held stable by the host while req is high
    typedef struct packed {
        macOpT                 op;
        logic [`MAC_IN_W-1:0]  a;
        logic [`MAC_IN_W-1:0]  b;
    } macReqT;

    // response word, valid while ack is high
    typedef struct packed {
        logic [`MAC_OUT_W-1:0] result;
        logic                  sat;
    } macRespT;

endpackage

/* source/signedMultiplier.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module signedMultiplier (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`MAC_IN_W-1:0]   a,
    input  logic [`MAC_IN_W-1:0]   b,
    input  logic                   prodLoad,
    output logic [`MAC_PROD_W-1:0] product
);

    // a sign-extended to product width
    logic [`MAC_PROD_W-1:0] aExt;

    // one partial-product row per bit of b
    logic [`MAC_PROD_W-1:0] rows [`MAC_IN_W];

    // running sums of the ripple chain
    logic [`MAC_PROD_W-1:0] sums [`MAC_IN_W];

    assign aExt = {{(`MAC_PROD_W-`MAC_IN_W){a[`MAC_IN_W-1]}}, a};

    ////////////////////////////////////////////////////////////////////////////
    // partial-product rows
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `MAC_IN_W; i++) begin : genRows
        logic [`MAC_PROD_W-1:0] pp;

        // gate by b[i], then shift into column i
        // sign bits of a fill the top, zeros fill below bit i
        assign pp = (aExt & {`MAC_PROD_W{b[i]}}) << i;

        if (i == `MAC_IN_W - 1) begin : genNeg
            // b's sign bit carries weight -2^15
            // so this row enters as its two's complement
            assign rows[i] = ~pp + 1'b1;
        end else begin : genPos
            assign rows[i] = pp;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ripple summation
    ////////////////////////////////////////////////////////////////////////////

    assign sums[0] = rows[0];

    for (genvar m = 1; m < `MAC_IN_W; m++) begin : genSum
        // each stage folds in one more row, wraps mod 2^32
        assign sums[m] = sums[m-1] + rows[m];
    end

    // product register, loaded one cycle after the operands
    always_ff @(posedge clk) begin
        if (!rstN) begin
            product <= '0;
        end else if (prodLoad) begin
            product <= sums[`MAC_IN_W-1];
        end
    end

endmodule

/* source/macAccumulator.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module macAccumulator (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   accEn,
    input  macPkg::macOpT          accOp,
    input  logic [`MAC_PROD_W-1:0] product,
    output macPkg::macRespT        respData
);

    import macPkg::*;

    // clamp limits for the 32-bit signed result
    localparam logic [`MAC_OUT_W-1:0] maxPos = {1'b0, {(`MAC_OUT_W-1){1'b1}}};
    localparam logic [`MAC_OUT_W-1:0] maxNeg = {1'b1, {(`MAC_OUT_W-1){1'b0}}};

    logic [`MAC_ACC_W-1:0] accReg;
    logic [`MAC_ACC_W-1:0] prodExt;

    // guard bits plus the result sign bit
    logic [`MAC_ACC_W-`MAC_OUT_W:0] upperBits;
    logic                            overRange;

    assign prodExt = {{(`MAC_ACC_W-`MAC_PROD_W){product[`MAC_PROD_W-1]}}, product};

    ////////////////////////////////////////////////////////////////////////////
    // accumulator register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            accReg <= '0;
        end else if (accEn) begin
            case (accOp)
                opMul:   accReg <= prodExt;
                opMac:   accReg <= accReg + prodExt;
                // clear, and the reserved code
                default: accReg <= '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // saturation
    ////////////////////////////////////////////////////////////////////////////

    // in range only when the top 9 bits are all copies of the sign
    assign upperBits = accReg[`MAC_ACC_W-1:`MAC_OUT_W-1];
    assign overRange = !((&upperBits) || !(|upperBits));

    always_comb begin
        respData.sat = overRange;
        if (!overRange) begin
            respData.result = accReg[`MAC_OUT_W-1:0];
        end else if (accReg[`MAC_ACC_W-1]) begin
            respData.result = maxNeg;
        end else begin
            respData.result = maxPos;
        end
    end

    // accumulator holds its value through every cycle without a strobe
    assertAccHold : assert property (
        @(posedge clk) disable iff (!rstN) !accEn |=> $stable(accReg)
    ) else $error("accumulator changed without accEn");

endmodule

/* source/macControl.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module macControl (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 req,
    input  macPkg::macReqT       reqData,
    output logic                 ack,
    output logic [`MAC_IN_W-1:0] opA,
    output logic [`MAC_IN_W-1:0] opB,
    output logic                 prodLoad,
    output logic                 accEn,
    output macPkg::macOpT        accOp
);

    import macPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stMult,
        stAccum,
        stHold
    } stateT;

    stateT  state;

    // command captured at acceptance and held until the next one
    macReqT opReg;

    ////////////////////////////////////////////////////////////////////////////
    // handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= stIdle;
            ack      <= 1'b0;
            prodLoad <= 1'b0;
            accEn    <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    // E0 latches the operands and raises the product strobe
                    if (req) begin
                        prodLoad <= 1'b1;
                        state    <= stMult;
                    end
                end
                stMult: begin
                    // product register loads at E0+1
                    prodLoad <= 1'b0;
                    accEn    <= 1'b1;
                    state    <= stAccum;
                end
                stAccum: begin
                    // accumulator updates at E0+2 alongside ack
                    accEn <= 1'b0;
                    ack   <= 1'b1;
                    state <= stHold;
                end
                stHold: begin
                    // wait out the host while respData stays frozen
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // operand register loads when req is accepted
    always_ff @(posedge clk) begin
        if (state == stIdle && req) begin
            opReg <= reqData;
        end
    end

    assign opA   = opReg.a;
    assign opB   = opReg.b;
    assign accOp = opReg.op;

    ////////////////////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////////////////////

    // ack only rises in answer to a held req
    assertAckNeedsReq : assert property (
        @(posedge clk) disable iff (!rstN) (!ack && !req) |=> !ack
    ) else $error("ack rose without req");

    // product and accumulate strobes never overlap
    assertStrobeExclusive : assert property (
        @(posedge clk) disable iff (!rstN) !(prodLoad && accEn)
    ) else $error("prodLoad and accEn high together");

    // reserved code 3 is reported here and executed as clear downstream
    assertNoReserved : assert property (
        @(posedge clk) disable iff (!rstN)
            (state == stIdle && req) |-> (reqData.op != 2'd3)
    ) else $error("reserved opcode accepted");

endmodule

/* source/macUnit.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module macUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            req,
    input  macPkg::macReqT  reqData,
    output logic            ack,
    output macPkg::macRespT respData
);

    import macPkg::*;

    // operand stage to multiplier
    logic [`MAC_IN_W-1:0]   opA;
    logic [`MAC_IN_W-1:0]   opB;
    logic                   prodLoad;

    // product stage to accumulator
    logic [`MAC_PROD_W-1:0] product;
    logic                   accEn;
    macOpT                  accOp;

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////////

    macControl uControl (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .reqData  (reqData),
        .ack      (ack),
        .opA      (opA),
        .opB      (opB),
        .prodLoad (prodLoad),
        .accEn    (accEn),
        .accOp    (accOp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    signedMultiplier uMult (
        .clk      (clk),
        .rstN     (rstN),
        .a        (opA),
        .b        (opB),
        .prodLoad (prodLoad),
        .product  (product)
    );

    // respData goes straight out to the host
    macAccumulator uAcc (
        .clk      (clk),
        .rstN     (rstN),
        .accEn    (accEn),
        .accOp    (accOp),
        .product  (product),
        .respData (respData)
    );

endmodule

/* test/macUnitTb.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module macUnitTb;

    import macPkg::*;

    // number of commands issued below sizes the watchdog
    localparam int numCmds = 71;

    logic    clk;
    logic    rstN;
    logic    req;
    macReqT  reqData;
    logic    ack;
    macRespT respData;

    integer  seed = 32'hb45b;

    // software accumulator kept at 40 bits
    longint  modelAcc;

    macUnit DUT (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .reqData  (reqData),
        .ack      (ack),
        .respData (respData)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // checking and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkVal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s mismatch, got %0d expected %0d",
                     $time, what, $signed(got), $signed(exp));
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic void applyModel(input macOpT op, input logic [15:0] a,
                                       input logic [15:0] b);
        longint prod;
        prod = longint'($signed(a)) * longint'($signed(b));
        if (op == opMul) begin
            modelAcc = prod;
        end else if (op == opMac) begin
            modelAcc = modelAcc + prod;
        end else begin
            modelAcc = 0;
        end
        // wrap like a 40-bit register
        modelAcc = (modelAcc <<< 24) >>> 24;
    endfunction

    // clamp to the 32-bit signed range
    function automatic longint modelResult();
        if (modelAcc > 64'sd2147483647) begin
            return 64'sd2147483647;
        end else if (modelAcc < -64'sd2147483648) begin
            return -64'sd2147483648;
        end
        return modelAcc;
    endfunction

    function automatic logic modelSat();
        return (modelAcc > 64'sd2147483647) || (modelAcc < -64'sd2147483648);
    endfunction

    function automatic longint dutResult();
        return longint'($signed(respData.result));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // one four-phase transaction
    ////////////////////////////////////////////////////////////////////////////

    // entered and left 1 ns after a rising edge
    task automatic doCmd(input macOpT op, input logic [15:0] a, input logic [15:0] b);
        int edges;
        applyModel(op, a, b);
        reqData.op = op;
        reqData.a  = a;
        reqData.b  = b;
        req        = 1'b1;
        edges      = 0;
        while (!ack) begin
            @(posedge clk);
            #1;
            edges++;
        end
        // E0 samples req and ack is registered at E0+2
        checkVal(edges, 3, "edges from req to ack");
        checkVal(dutResult(), modelResult(), "result");
        checkVal(respData.sat, modelSat(), "sat");
        // host stalls while ack and response stay put
        repeat (4) begin
            @(posedge clk);
            #1;
            checkVal(ack, 1'b1, "ack while req held");
            checkVal(dutResult(), modelResult(), "result while req held");
            checkVal(respData.sat, modelSat(), "sat while req held");
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        checkVal(ack, 1'b0, "ack after req released");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testCorners();
        doCmd(opMul, 16'h8000, 16'h8000);
        checkVal(dutResult(), 64'sd1073741824, "min times min");
        doCmd(opMul, 16'h8000, 16'h7fff);
        checkVal(dutResult(), -64'sd1073709056, "min times max");
        doCmd(opMul, 16'hffff, 16'hffff);
        checkVal(dutResult(), 64'sd1, "-1 times -1");
        doCmd(opMul, 16'h0000, 16'hfffb);
        checkVal(dutResult(), 64'sd0, "0 times -5");
        checkVal(respData.sat, 1'b0, "corner sat");
    endtask

    task automatic testRandomMul();
        logic [31:0] rnd;
        repeat (50) begin
            rnd = $random(seed);
            doCmd(opMul, rnd[15:0], rnd[31:16]);
        end
    endtask

    // running sum after a clear
    task automatic testChain();
        logic [31:0] rnd;
        doCmd(opClear, 16'h0, 16'h0);
        repeat (6) begin
            rnd = $random(seed);
            doCmd(opMac, rnd[15:0], rnd[31:16]);
        end
    endtask

    task automatic testSaturation();
        doCmd(opClear, 16'h0, 16'h0);
        // 2^30 per step passes the top on the second
        repeat (3) begin
            doCmd(opMac, 16'h8000, 16'h8000);
        end
        checkVal(dutResult(), 64'sd2147483647, "positive clamp");
        checkVal(respData.sat, 1'b1, "positive sat");
        doCmd(opClear, 16'h0, 16'h0);
        repeat (3) begin
            doCmd(opMac, 16'h8000, 16'h7fff);
        end
        checkVal(dutResult(), -64'sd2147483648, "negative clamp");
        checkVal(respData.sat, 1'b1, "negative sat");
    endtask

    task automatic testClear();
        doCmd(opClear, 16'h0, 16'h0);
        checkVal(dutResult(), 64'sd0, "result after clear");
        checkVal(respData.sat, 1'b0, "sat after clear");
        // 123 times -45
        doCmd(opMac, 16'd123, 16'hffd3);
        checkVal(dutResult(), -64'sd5535, "mac after clear");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        req      = 1'b0;
        reqData  = '0;
        modelAcc = 0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkVal(ack, 1'b0, "ack after reset");
        checkVal(dutResult(), 64'sd0, "result after reset");
        testCorners();
        testRandomMul();
        testChain();
        testSaturation();
        testClear();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // a transaction with its stall takes 8 cycles of the 20 allowed
    initial begin
        #(numCmds * 20 * 8);
        $display("simulation timed out, ack never completed");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* flist.f */
+incdir+source
source/macPkg.sv
source/signedMultiplier.sv
source/macAccumulator.sv
source/macControl.sv
source/macUnit.sv
test/macUnitTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the macUnit testbench with Verilator

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
    echo "cannot enter project root"
    exit $status
fi

verilator --binary --assert -Wno-fatal --top-module macUnitTb -f flist.f -o macUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/macUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
